// File: gcn_defs.svh
`ifndef GCN_DEFS_SVH
`define GCN_DEFS_SVH

// width of one weight and of one feature value
`define GCN_DATA_W 8

// column accumulator width
// 24 rows of 8x8 signed products fit with plenty of headroom
`define GCN_ACC_W 24

// weight rows, also the range of a feature index
`define GCN_W_ROWS 24

// weight columns, one column memory each
`define GCN_W_COLS 4

`endif

// File: gcn_pkg.sv
`default_nettype none

`include "gcn_defs.svh"

package gcn_pkg;

  // signed data words
  typedef logic signed [`GCN_DATA_W-1:0] weight_t;
  typedef logic signed [`GCN_DATA_W-1:0] feat_val_t;
  typedef logic signed [`GCN_ACC_W-1:0]  acc_t;

  // index and address widths
  typedef logic [$clog2(`GCN_W_ROWS)-1:0]              row_idx_t;
  typedef logic [$clog2(`GCN_W_COLS)-1:0]              col_idx_t;
  typedef logic [$clog2(`GCN_W_ROWS*`GCN_W_COLS)-1:0] src_addr_t;

  // one entry of a sparse feature row
  typedef struct packed {
    row_idx_t  index;
    feat_val_t value;
    logic      last;
  } feat_entry_t;

  // sums[c] is the result for column c
  typedef struct packed {
    acc_t [`GCN_W_COLS-1:0] sums;
  } out_row_t;

endpackage

`default_nettype wire

// File: gcn_weight_top.sv
`default_nettype none

`include "gcn_defs.svh"

module gcn_weight_top
  import gcn_pkg::*;
(
  input  wire          clk,
  input  wire          rst_n,

  input  logic         src_wr_en,
  input  src_addr_t    src_wr_addr,
  input  weight_t      src_wr_data,

  input  logic         w_valid,
  output logic         w_ready,

  input  logic         feat_valid,
  input  feat_entry_t  feat_entry,

  output logic         out_valid,
  output out_row_t     out_row
);

  src_addr_t                   src_rd_addr;
  weight_t                     src_rd_data;
  row_idx_t                    col_rd_idx;
  weight_t [`GCN_W_COLS-1:0]   col_weights;

  // row-major source weights, registered read
  weight_bram #(
    .DEPTH      (`GCN_W_ROWS * `GCN_W_COLS),
    .ADDR_W     ($bits(src_addr_t)),
    .RD_LATENCY (1)
  ) src_mem_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (src_wr_en),
    .wr_addr (src_wr_addr),
    .wr_data (src_wr_data),
    .rd_addr (src_rd_addr),
    .rd_data (src_rd_data)
  );

  // the source memory reads every cycle, the enable only tracks requests
  weight_loader loader_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .src_rd_en   (),
    .src_rd_addr (src_rd_addr),
    .src_rd_data (src_rd_data),
    .col_rd_idx  (col_rd_idx),
    .col_weights (col_weights)
  );

  sparse_row_matmul matmul_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .weights_ready (w_ready),
    .feat_valid    (feat_valid),
    .feat_entry    (feat_entry),
    .col_rd_idx    (col_rd_idx),
    .col_weights   (col_weights),
    .out_valid     (out_valid),
    .out_row       (out_row)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is nonzero when the build fails or the run ends in $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gcn_weight -f vlog.f -o tb_gcn_weight &&
./obj_dir/tb_gcn_weight || exit 1

// File: sparse_row_matmul.sv
`default_nettype none

`include "gcn_defs.svh"

module sparse_row_matmul
  import gcn_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,

  input  logic                          weights_ready,

  input  logic                          feat_valid,
  input  feat_entry_t                   feat_entry,

  output row_idx_t                      col_rd_idx,
  input  weight_t [`GCN_W_COLS-1:0]     col_weights,

  output logic                          out_valid,
  output out_row_t                      out_row
);

  localparam int PROD_W = 2 * `GCN_DATA_W;

  // running column sums for the row being accumulated
  acc_t [`GCN_W_COLS-1:0]        acc;
  // sums including the product of the current entry
  acc_t [`GCN_W_COLS-1:0]        acc_next;
  logic signed [PROD_W-1:0]      prod [`GCN_W_COLS];

  // all column memories are read at the entry index in the same cycle
  assign col_rd_idx = feat_entry.index;

  always_comb begin
    for (int c = 0; c < `GCN_W_COLS; c++) begin
      prod[c]     = feat_entry.value * col_weights[c];
      // signed add, the product is sign-extended to the accumulator width
      acc_next[c] = acc[c] + prod[c];
    end
  end

  // accumulators, cleared on the entry that closes a row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (feat_valid) begin
      if (feat_entry.last) begin
        acc <= '0;
      end else begin
        acc <= acc_next;
      end
    end
  end

  // result strobe, high for exactly one cycle per row
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= feat_valid && feat_entry.last;
    end
  end

  // held until the next row closes
  always_ff @(posedge clk) begin
    if (feat_valid && feat_entry.last) begin
      out_row.sums <= acc_next;
    end
  end

  // features may only stream in once the column memories are loaded
  a_feat_after_load: assert property (
    @(posedge clk) disable iff (!rst_n)
    feat_valid |-> weights_ready
  );

endmodule

`default_nettype wire

// File: tb_gcn_weight.sv
`default_nettype none

`include "gcn_defs.svh"

module tb_gcn_weight
  import gcn_pkg::*;
();

  localparam int N_ELEM       = `GCN_W_ROWS * `GCN_W_COLS;
  localparam int LOAD_TIMEOUT = 40 * N_ELEM;

  logic        clk;
  logic        rst_n;
  logic        src_wr_en;
  src_addr_t   src_wr_addr;
  weight_t     src_wr_data;
  logic        w_valid;
  logic        w_ready;
  logic        feat_valid;
  feat_entry_t feat_entry;
  logic        out_valid;
  out_row_t    out_row;

  // reference copy of the row-major weights
  weight_t     model_w [`GCN_W_ROWS][`GCN_W_COLS];
  // entries still to drive and the rows they must produce
  feat_entry_t ent_q[$];
  out_row_t    exp_q[$];
  // rows from the sparse test, replayed after the reload
  feat_entry_t saved_q[$];
  int          run_sum [`GCN_W_COLS];
  bit          pulse_due;

  gcn_weight_top dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .src_wr_en   (src_wr_en),
    .src_wr_addr (src_wr_addr),
    .src_wr_data (src_wr_data),
    .w_valid     (w_valid),
    .w_ready     (w_ready),
    .feat_valid  (feat_valid),
    .feat_entry  (feat_entry),
    .out_valid   (out_valid),
    .out_row     (out_row)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_level(input string name, input bit actual, input bit expected);
    if (actual !== expected) begin
      stop_run($sformatf("[ERROR] %s got %h expected %h", name, actual, expected));
    end
  endtask

  task automatic check_out_row(input out_row_t actual, input out_row_t expected);
    for (int c = 0; c < `GCN_W_COLS; c++) begin
      if (actual.sums[c] !== expected.sums[c]) begin
        stop_run($sformatf("[ERROR] out_row.sums[%0d] got %h expected %h",
                           c, actual.sums[c], expected.sums[c]));
      end
    end
  endtask

  task automatic apply_reset;
    @(negedge clk);
    rst_n       = 1'b0;
    src_wr_en   = 1'b0;
    w_valid     = 1'b0;
    feat_valid  = 1'b0;
    feat_entry  = '0;
    pulse_due   = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    check_level("w_ready", w_ready, 1'b0);
    check_level("out_valid", out_valid, 1'b0);
  endtask

  // fresh random weights into the source memory and the model
  task automatic write_weights;
    weight_t w;
    for (int r = 0; r < `GCN_W_ROWS; r++) begin
      for (int c = 0; c < `GCN_W_COLS; c++) begin
        w = weight_t'($urandom);
        @(negedge clk);
        src_wr_en   = 1'b1;
        src_wr_addr = src_addr_t'(r * `GCN_W_COLS + c);
        src_wr_data = w;
        model_w[r][c] = w;
      end
    end
    @(negedge clk);
    src_wr_en = 1'b0;
  endtask

  // queue one entry, the expected row is built as the entries come in
  task automatic push_entry(input int idx, input int val, input bit last);
    feat_entry_t e;
    out_row_t    exp_row;
    e.index = row_idx_t'(idx);
    e.value = feat_val_t'(val);
    e.last  = last;
    ent_q.push_back(e);
    for (int c = 0; c < `GCN_W_COLS; c++) begin
      run_sum[c] += int'(e.value) * int'(model_w[idx][c]);
    end
    if (last) begin
      for (int c = 0; c < `GCN_W_COLS; c++) begin
        exp_row.sums[c] = acc_t'(run_sum[c]);
        run_sum[c]      = 0;
      end
      exp_q.push_back(exp_row);
    end
  endtask

  // one clock: check the result of the last edge, then drive the next input
  task automatic step_cycle(input bit valid, input feat_entry_t e);
    out_row_t exp_row;
    @(negedge clk);
    check_level("out_valid", out_valid, pulse_due);
    if (pulse_due) begin
      if (exp_q.size() == 0) begin
        stop_run("out_valid pulsed but the model holds no expected row");
      end else begin
        exp_row = exp_q.pop_front();
        check_out_row(out_row, exp_row);
      end
    end
    feat_valid = valid;
    feat_entry = e;
    pulse_due  = valid && e.last;
  endtask

  task automatic stream_entries(input bit idle_after_row);
    feat_entry_t e;
    while (ent_q.size() > 0) begin
      e = ent_q.pop_front();
      step_cycle(1'b1, e);
      if (idle_after_row && e.last) begin
        step_cycle(1'b0, '0);
      end
    end
    // last result, then a quiet cycle with no pulse
    step_cycle(1'b0, '0);
    step_cycle(1'b0, '0);
    if (exp_q.size() != 0) begin
      stop_run("some feature rows never produced an out_valid pulse");
    end
  endtask

  // behavior 1
  task automatic load_held_valid;
    @(negedge clk);
    check_level("w_ready", w_ready, 1'b0);
    w_valid = 1'b1;
    for (int k = 1; k <= N_ELEM + 1; k++) begin
      @(negedge clk);
      check_level("w_ready", w_ready, k == N_ELEM + 1);
    end
    w_valid = 1'b0;
  endtask

  // behavior 2, unit feature at every index returns that weight row
  task automatic unit_row_sweep;
    for (int i = 0; i < `GCN_W_ROWS; i++) begin
      push_entry(i, 1, 1'b1);
    end
    stream_entries(1'b1);
  endtask

  // behavior 3
  task automatic sparse_random_rows;
    int n_ent;
    int idx;
    int val;
    idx = 0;
    for (int r = 0; r < 8; r++) begin
      n_ent = $urandom_range(2, 6);
      for (int k = 0; k < n_ent; k++) begin
        // entry 1 repeats the index of entry 0
        if (k != 1) begin
          idx = $urandom_range(0, `GCN_W_ROWS - 1);
        end
        if (k == 0) begin
          val = -int'($urandom_range(1, 128));
        end else begin
          val = int'($urandom_range(0, 255)) - 128;
        end
        push_entry(idx, val, k == n_ent - 1);
        saved_q.push_back(ent_q[$]);
      end
    end
    stream_entries(1'b1);
  endtask

  // behavior 4, the next row starts in the cycle the previous one shows
  task automatic back_to_back_rows;
    int n_ent;
    for (int r = 0; r < 10; r++) begin
      n_ent = $urandom_range(1, 4);
      for (int k = 0; k < n_ent; k++) begin
        push_entry($urandom_range(0, `GCN_W_ROWS - 1),
                   int'($urandom_range(0, 255)) - 128, k == n_ent - 1);
      end
    end
    stream_entries(1'b0);
  endtask

  // behavior 5
  task automatic reload_with_gaps;
    int cycles;
    apply_reset();
    write_weights();
    check_level("w_ready", w_ready, 1'b0);
    cycles = 0;
    while (!w_ready) begin
      @(negedge clk);
      w_valid = 1'($urandom_range(0, 1));
      cycles++;
      if (cycles > LOAD_TIMEOUT) begin
        stop_run("timeout while waiting for w_ready during the gapped load");
      end
    end
    w_valid = 1'b0;
    foreach (saved_q[i]) begin
      push_entry(int'(saved_q[i].index), int'(saved_q[i].value), saved_q[i].last);
    end
    stream_entries(1'b1);
    check_level("w_ready", w_ready, 1'b1);
  endtask

  initial begin
    void'($urandom(32'h9a7adac3));
    rst_n       = 1'b0;
    src_wr_en   = 1'b0;
    src_wr_addr = '0;
    src_wr_data = '0;
    w_valid     = 1'b0;
    feat_valid  = 1'b0;
    feat_entry  = '0;
    pulse_due   = 1'b0;
    for (int c = 0; c < `GCN_W_COLS; c++) begin
      run_sum[c] = 0;
    end
    apply_reset();
    write_weights();
    load_held_valid();
    unit_row_sweep();
    sparse_random_rows();
    back_to_back_rows();
    reload_with_gaps();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
gcn_pkg.sv
weight_bram.sv
weight_loader.sv
sparse_row_matmul.sv
gcn_weight_top.sv
tb_gcn_weight.sv

// File: weight_bram.sv
`default_nettype none

module weight_bram
  import gcn_pkg::*;
#(
  parameter int DEPTH      = 16,
  parameter int ADDR_W     = 4,
  parameter int RD_LATENCY = 1
) (
  input  wire               clk,
  input  wire               rst_n,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  weight_t           wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output weight_t           rd_data
);

  weight_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  generate
    if (RD_LATENCY == 0) begin : g_rd_comb
      // asynchronous read, data follows the address in the same cycle
      assign rd_data = mem[rd_addr];
    end else begin : g_rd_reg
      always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
      end
    end
  endgenerate

  // writes must stay inside the array
  a_wr_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (wr_addr < DEPTH)
  );

endmodule

`default_nettype wire

// File: weight_loader.sv
`default_nettype none

`include "gcn_defs.svh"

module weight_loader
  import gcn_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,

  input  logic                          w_valid,
  output logic                          w_ready,

  output logic                          src_rd_en,
  output src_addr_t                     src_rd_addr,
  input  weight_t                       src_rd_data,

  input  row_idx_t                      col_rd_idx,
  output weight_t [`GCN_W_COLS-1:0]     col_weights
);

  localparam int unsigned N_ELEM = `GCN_W_ROWS * `GCN_W_COLS;
  localparam int          SRC_W  = $bits(src_addr_t);
  localparam int          ROW_W  = $bits(row_idx_t);

  // one spare bit so the counter can park at N_ELEM
  logic [SRC_W:0]              rd_cnt;
  logic                        rd_pending;
  row_idx_t                    wr_row;
  col_idx_t                    wr_col;
  logic [`GCN_W_COLS-1:0]      col_wr_en;
  logic                        last_wr;

  // read side of the copy, the parked counter ends the reads
  assign src_rd_en   = w_valid && (rd_cnt < N_ELEM);
  assign src_rd_addr = rd_cnt[SRC_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_cnt     <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= src_rd_en;
      if (src_rd_en) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  // write side, data arrives one cycle after each issued read
  assign last_wr = rd_pending &&
                   (wr_row == row_idx_t'(`GCN_W_ROWS - 1)) &&
                   (wr_col == col_idx_t'(`GCN_W_COLS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_row <= '0;
      wr_col <= '0;
    end else if (rd_pending) begin
      if (wr_col == col_idx_t'(`GCN_W_COLS - 1)) begin
        wr_col <= '0;
        // wrap the row after the final element
        wr_row <= last_wr ? '0 : wr_row + 1'b1;
      end else begin
        wr_col <= wr_col + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ready <= 1'b0;
    end else if (last_wr) begin
      // sticky until the next reset
      w_ready <= 1'b1;
    end
  end

  // one column memory per output column
  genvar c;
  generate
    for (c = 0; c < `GCN_W_COLS; c++) begin : g_col
      assign col_wr_en[c] = rd_pending && (wr_col == col_idx_t'(c));

      weight_bram #(
        .DEPTH      (`GCN_W_ROWS),
        .ADDR_W     (ROW_W),
        .RD_LATENCY (0)
      ) col_mem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (col_wr_en[c]),
        .wr_addr (wr_row),
        .wr_data (src_rd_data),
        .rd_addr (col_rd_idx),
        .rd_data (col_weights[c])
      );
    end
  endgenerate

  // the copy is one-shot per reset
  a_no_read_after_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    w_ready |-> !src_rd_en
  );

  // returning data lands at the row and column of the address that was read
  a_col_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_pending |->
      (int'(wr_row) * `GCN_W_COLS + int'(wr_col) == int'(rd_cnt) - 1)
  );

endmodule

`default_nettype wire
